// File: Makefile
# Verilator build and run of the bundle front end testbench

SIM := obj_dir/Vtb_fetch

.PHONY: all run clean

all: run

$(SIM): src.f fe_cfg.svh fe_pkg.sv bundle_fetch.sv slot_decode.sv return_stack.sv \
		instruction_pointer.sv fetch_top.sv tb_fetch.sv
	verilator --binary --assert -j 0 --top-module tb_fetch -f src.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: bundle_fetch.sv
/*
 * four-phase requester to instruction memory
 * one fetch_start pulse fetches one bundle, fetch_done pulses once the handshake closes
 */

`default_nettype none

`include "fe_cfg.svh"

module bundle_fetch import fe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetch_start,
	input  logic [`FE_ADDR_W-1:0] fetch_addr,
	output logic                  fetch_done,
	output bundle_t               fetch_bundle,
	output logic                  mem_req,
	output logic [`FE_ADDR_W-1:0] mem_addr,
	input  logic                  mem_ack,
	input  bundle_t               mem_data
);

	typedef enum logic [1:0] {
		bf_idle,
		bf_req,
		bf_release
	} bf_state_e;

	bf_state_e state;

	// ==============================
	// handshake sequencing
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bf_idle;
			mem_req <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				bf_idle: begin
					if (fetch_start) begin
						mem_req <= 1'b1;
						state <= bf_req;
					end
				end
				bf_req: begin
					// memory has the data on the bus, close our side of the handshake
					if (mem_ack) begin
						mem_req <= 1'b0;
						state <= bf_release;
					end
				end
				bf_release: begin
					if (!mem_ack) begin
						fetch_done <= 1'b1;
						state <= bf_idle;
					end
				end
				default: state <= bf_idle;
			endcase
		end
	end

	// address and data registers
	always_ff @(posedge clk) begin
		if (state == bf_idle && fetch_start)
			mem_addr <= {fetch_addr[`FE_ADDR_W-1:4], 4'h0};
		if (state == bf_req && mem_ack)
			fetch_bundle <= mem_data;
	end

	// the responder may sample the address at any point of the request phase
	a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req |=> !mem_req || $stable(mem_addr));

endmodule

`default_nettype wire

// File: fe_cfg.svh
/*
 * configuration macros for the bundle front end
 * include this before any module or package that sizes ports or state from them
 */

`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// instruction pointer width, bits above the low nibble are the bundle address
`define FE_ADDR_W 32

// slots per bundle and instruction width
`define FE_SLOTS 3
`define FE_INSN_W 40

// reset pointer is bundle FFFFFC0, slot 0
`define FE_RST_IP 32'hFFFF_FC00

// return address stack entries
`define FE_RAS_DEPTH 4

`endif

// File: fe_pkg.sv
/*
 * shared types for the bundle front end
 * modules pull these in with a wildcard import in their header
 */

`default_nettype none

`include "fe_cfg.svh"

package fe_pkg;

	// opcode class held in instruction bits 39 to 37, unlisted codes decode as alu
	typedef enum logic [2:0] {
		ic_alu      = 3'd0,
		ic_br_taken = 3'd1,
		ic_br_not   = 3'd2,
		ic_jc       = 3'd3,
		ic_ret      = 3'd4
	} insn_class_e;

	// sequencing states of the instruction pointer unit
	typedef enum logic [2:0] {
		fs_idle,
		fs_miss,
		fs_fetch,
		fs_decode,
		fs_issue,
		fs_update
	} fetch_state_e;

	// 128-bit bundle, slot 0 sits in the low bits and the template on top
	typedef struct packed {
		logic [7:0]                               tmpl;
		logic [`FE_SLOTS-1:0][`FE_INSN_W-1:0] insn;
	} bundle_t;

	typedef struct packed {
		logic                  valid;
		insn_class_e           cls;
		logic [`FE_ADDR_W-1:0] target;
	} slot_info_t;

	typedef struct packed {
		logic [`FE_ADDR_W-1:0] ip;
		logic [`FE_SLOTS-1:0]  mask;
		bundle_t               bundle;
	} issue_t;

endpackage

`default_nettype wire

// File: fetch_top.sv
/*
 * top of the bundle front end
 * ties the fetcher, slot predecode, return stack and pointer unit to the three ports
 */

`default_nettype none

`include "fe_cfg.svh"

module fetch_top import fe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  mem_req,
	output logic [`FE_ADDR_W-1:0] mem_addr,
	input  logic                  mem_ack,
	input  bundle_t               mem_data,
	output logic                  issue_req,
	output issue_t                issue_data,
	input  logic                  issue_ack,
	input  logic                  miss_req,
	input  logic [`FE_ADDR_W-1:0] miss_ip,
	output logic                  miss_ack
);

	logic                          fetch_start;
	logic [`FE_ADDR_W-1:0]         fetch_addr;
	logic                          fetch_done;
	bundle_t                       fetch_bundle;
	slot_info_t [`FE_SLOTS-1:0] slots;
	logic                          ras_push;
	logic                          ras_pop;
	logic [`FE_ADDR_W-1:0]         ras_push_addr;
	logic [`FE_ADDR_W-1:0]         ras_top;
	logic [`FE_ADDR_W-1:0]         cur_ip;

	bundle_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.fetch_start  (fetch_start),
		.fetch_addr   (fetch_addr),
		.fetch_done   (fetch_done),
		.fetch_bundle (fetch_bundle),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.mem_ack      (mem_ack),
		.mem_data     (mem_data)
	);

	slot_decode u_decode (
		.ip     (cur_ip),
		.bundle (fetch_bundle),
		.slots  (slots)
	);

	// the pointer unit reads the top directly, so the empty flag stays local
	return_stack u_ras (
		.clk       (clk),
		.rst       (rst),
		.push      (ras_push),
		.pop       (ras_pop),
		.push_addr (ras_push_addr),
		.top       (ras_top),
		.empty     ()
	);

	instruction_pointer u_ip (
		.clk           (clk),
		.rst           (rst),
		.miss_req      (miss_req),
		.miss_ip       (miss_ip),
		.miss_ack      (miss_ack),
		.fetch_start   (fetch_start),
		.fetch_addr    (fetch_addr),
		.fetch_done    (fetch_done),
		.fetch_bundle  (fetch_bundle),
		.slots         (slots),
		.ras_push      (ras_push),
		.ras_pop       (ras_pop),
		.ras_push_addr (ras_push_addr),
		.ras_top       (ras_top),
		.issue_req     (issue_req),
		.issue_data    (issue_data),
		.issue_ack     (issue_ack),
		.ip            (cur_ip)
	);

endmodule

`default_nettype wire

// File: instruction_pointer.sv
/*
 * instruction pointer and bundle sequencer
 * runs miss, fetch, decode, issue and update for one bundle at a time
 * and picks the next pointer from the first redirecting slot
 */

`default_nettype none

`include "fe_cfg.svh"

module instruction_pointer import fe_pkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          miss_req,
	input  logic [`FE_ADDR_W-1:0]         miss_ip,
	output logic                          miss_ack,
	output logic                          fetch_start,
	output logic [`FE_ADDR_W-1:0]         fetch_addr,
	input  logic                          fetch_done,
	input  bundle_t                       fetch_bundle,
	input  slot_info_t [`FE_SLOTS-1:0] slots,
	output logic                          ras_push,
	output logic                          ras_pop,
	output logic [`FE_ADDR_W-1:0]         ras_push_addr,
	input  logic [`FE_ADDR_W-1:0]         ras_top,
	output logic                          issue_req,
	output issue_t                        issue_data,
	input  logic                          issue_ack,
	output logic [`FE_ADDR_W-1:0]         ip
);

	localparam int SLOT_W = $clog2(`FE_SLOTS);

	fetch_state_e                  state;
	slot_info_t [`FE_SLOTS-1:0] slots_q;
	logic                          found;
	logic [SLOT_W-1:0]             sel_slot;
	insn_class_e                   sel_cls;
	logic [`FE_SLOTS-1:0]          issue_mask;
	logic [`FE_ADDR_W-1:0]         seq_ip;
	logic [`FE_ADDR_W-1:0]         next_ip;

	// ==============================
	// sequencer
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fs_idle;
			ip <= `FE_RST_IP;
			issue_req <= 1'b0;
		end else begin
			case (state)
				fs_idle: begin
					// a pending miss wins over the next sequential fetch
					if (miss_req) begin
						ip <= miss_ip;
						state <= fs_miss;
					end else begin
						state <= fs_fetch;
					end
				end
				fs_miss: begin
					if (!miss_req)
						state <= fs_idle;
				end
				fs_fetch: begin
					if (fetch_done)
						state <= fs_decode;
				end
				fs_decode: begin
					issue_req <= 1'b1;
					state <= fs_issue;
				end
				fs_issue: begin
					// req is only low here after the back end has acked
					if (issue_req && issue_ack)
						issue_req <= 1'b0;
					else if (!issue_req && !issue_ack)
						state <= fs_update;
				end
				fs_update: begin
					ip <= next_ip;
					state <= fs_idle;
				end
				default: state <= fs_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fs_decode)
			slots_q <= slots;
	end

	assign miss_ack = (state == fs_miss);
	assign fetch_start = (state == fs_idle) && !miss_req;
	assign fetch_addr = ip;

	// ==============================
	// redirect selection
	// ==============================

	// scan valid slots in order and stop at the first taken branch, call or return
	always_comb begin
		found = 1'b0;
		sel_slot = '0;
		sel_cls = ic_alu;
		issue_mask = '0;
		for (int s = 0; s < `FE_SLOTS; s++) begin
			if (slots_q[s].valid && !found) begin
				issue_mask[s] = 1'b1;
				if (slots_q[s].cls inside {ic_br_taken, ic_jc, ic_ret}) begin
					found = 1'b1;
					sel_slot = SLOT_W'(s);
					sel_cls = slots_q[s].cls;
				end
			end
		end
	end

	assign seq_ip = {ip[`FE_ADDR_W-1:4] + 1'b1, 4'h0};

	always_comb begin
		next_ip = seq_ip;
		if (found) begin
			if (sel_cls == ic_ret)
				next_ip = ras_top;
			else
				next_ip = slots_q[sel_slot].target;
		end
	end

	// return address is the slot after the call, the last slot returns to the next bundle
	always_comb begin
		case (sel_slot)
			SLOT_W'(0): ras_push_addr = {ip[`FE_ADDR_W-1:4], 4'h5};
			SLOT_W'(1): ras_push_addr = {ip[`FE_ADDR_W-1:4], 4'hA};
			default:    ras_push_addr = seq_ip;
		endcase
	end

	assign ras_push = (state == fs_update) && found && (sel_cls == ic_jc);
	assign ras_pop = (state == fs_update) && found && (sel_cls == ic_ret);

	assign issue_data = '{ip: ip, mask: issue_mask, bundle: fetch_bundle};

	a_issue_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(issue_req) |-> state == fs_issue);

endmodule

`default_nettype wire

// File: return_stack.sv
/*
 * return address stack, pushed by jump-call and popped by return
 * a push onto a full stack loses the oldest entry, an empty stack reads the reset pointer
 */

`default_nettype none

`include "fe_cfg.svh"

module return_stack (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  push,
	input  logic                  pop,
	input  logic [`FE_ADDR_W-1:0] push_addr,
	output logic [`FE_ADDR_W-1:0] top,
	output logic                  empty
);

	localparam int DEPTH = `FE_RAS_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// entry 0 is the top, older entries shift toward the end
	logic [`FE_ADDR_W-1:0] entry [DEPTH];
	logic [CNT_W-1:0]      count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (push) begin
			if (count != CNT_W'(DEPTH))
				count <= count + 1'b1;
		end else if (pop) begin
			if (count != '0)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			entry[0] <= push_addr;
			for (int i = 1; i < DEPTH; i++)
				entry[i] <= entry[i-1];
		end else if (pop) begin
			for (int i = 0; i < DEPTH - 1; i++)
				entry[i] <= entry[i+1];
		end
	end

	assign empty = (count == '0);
	assign top = empty ? `FE_RST_IP : entry[0];

	// one redirecting slot per bundle, so a call and a return never share an update
	a_push_pop_excl: assert property (@(posedge clk) disable iff (rst) !(push && pop));

endmodule

`default_nettype wire

// File: slot_decode.sv
/*
 * combinational predecode of the three slots of a bundle
 * gives each slot a valid bit from the pointer nibble, its class and its target
 */

`default_nettype none

`include "fe_cfg.svh"

module slot_decode import fe_pkg::*; (
	input  logic [`FE_ADDR_W-1:0]         ip,
	input  bundle_t                       bundle,
	output slot_info_t [`FE_SLOTS-1:0] slots
);

	localparam int BA_W = `FE_ADDR_W - 4;

	logic [1:0]      cur_slot;
	logic [BA_W-1:0] cur_ba;

	// target slot code to pointer nibble, code 3 falls back to slot 0
	function automatic logic [3:0] slot_nibble(input logic [1:0] code);
		case (code)
			2'd1:    slot_nibble = 4'h5;
			2'd2:    slot_nibble = 4'hA;
			default: slot_nibble = 4'h0;
		endcase
	endfunction

	function automatic insn_class_e decode_class(input logic [2:0] op);
		case (op)
			ic_br_taken, ic_br_not, ic_jc, ic_ret: decode_class = insn_class_e'(op);
			default:                               decode_class = ic_alu;
		endcase
	endfunction

	assign cur_ba = ip[`FE_ADDR_W-1:4];

	// starting slot from the low nibble of the pointer
	always_comb begin
		case (ip[3:0])
			4'h5:    cur_slot = 2'd1;
			4'hA:    cur_slot = 2'd2;
			default: cur_slot = 2'd0;
		endcase
	end

	for (genvar s = 0; s < `FE_SLOTS; s++) begin : g_slot
		logic [`FE_INSN_W-1:0] insn;
		logic [BA_W-1:0]       br_ba;
		logic [3:0]            tgt_nib;
		insn_class_e           cls;

		assign insn = bundle.insn[s];
		assign cls = decode_class(insn[39:37]);
		assign tgt_nib = slot_nibble(insn[1:0]);

		// branch displacement counts in whole bundles
		assign br_ba = cur_ba + {{(BA_W-16){insn[36]}}, insn[36:21]};

		assign slots[s].valid = (cur_slot <= 2'(s));
		assign slots[s].cls = cls;
		assign slots[s].target = (cls == ic_jc) ? {insn[9 +: BA_W], tgt_nib} : {br_ba, tgt_nib};
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
fe_pkg.sv
bundle_fetch.sv
slot_decode.sv
return_stack.sv
instruction_pointer.sv
fetch_top.sv
tb_fetch.sv

// File: tb_fetch.sv
/*
 * testbench for the bundle front end, seeded random memory image and reference model
 * a memory responder, an issue acknowledger and a miss driver run against fetch_top
 */

`default_nettype none

`include "fe_cfg.svh"

module tb_fetch import fe_pkg::*; ();

	localparam int AW = `FE_ADDR_W;
	localparam int NS = `FE_SLOTS;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_BUNDLES = 300;
	// 400 bundles of at most 20 cycles each, on top of reset
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 400 * 20;
	localparam logic [AW-1:0] RST_IP = `FE_RST_IP;

	logic          clk = 1'b0;
	logic          rst;
	logic          mem_req;
	logic [AW-1:0] mem_addr;
	logic          mem_ack;
	bundle_t       mem_data;
	logic          issue_req;
	issue_t        issue_data;
	logic          issue_ack;
	logic          miss_req;
	logic [AW-1:0] miss_ip;
	logic          miss_ack;

	integer        seed = 32'h175a_a205;
	logic [127:0]  image [256];
	logic [AW-1:0] model_ip = RST_IP;
	logic [AW-1:0] ras_model [$];
	logic [AW-1:0] last_fetch_addr;
	logic [AW-1:0] miss_target;
	logic          miss_pending = 1'b0;
	int            bundles_issued = 0;
	int            misses_done = 0;
	int            overflow_pushes = 0;
	int            empty_pops = 0;
	int            not_taken_seen = 0;

	fetch_top dut (
		.clk        (clk),
		.rst        (rst),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_data   (mem_data),
		.issue_req  (issue_req),
		.issue_data (issue_data),
		.issue_ack  (issue_ack),
		.miss_req   (miss_req),
		.miss_ip    (miss_ip),
		.miss_ack   (miss_ack)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired with %0d of %0d bundles issued", bundles_issued, NUM_BUNDLES);
		$display("Checks failed");
		$fatal(1, "simulation timed out");
	end

	// ==============================
	// helpers
	// ==============================

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("** Error at time %0t: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			$display("Checks failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// every sample and every drive happens one time unit after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step();
	endtask

	function automatic int rand_delay();
		rand_delay = $unsigned($random(seed)) % 4;
	endfunction

	function automatic insn_class_e op_class(input logic [2:0] op);
		case (op)
			3'd1:    op_class = ic_br_taken;
			3'd2:    op_class = ic_br_not;
			3'd3:    op_class = ic_jc;
			3'd4:    op_class = ic_ret;
			default: op_class = ic_alu;
		endcase
	endfunction

	function automatic logic [3:0] target_nibble(input logic [1:0] code);
		case (code)
			2'd1:    target_nibble = 4'h5;
			2'd2:    target_nibble = 4'hA;
			default: target_nibble = 4'h0;
		endcase
	endfunction

	function automatic int start_slot(input logic [3:0] nib);
		case (nib)
			4'h5:    start_slot = 1;
			4'hA:    start_slot = 2;
			default: start_slot = 0;
		endcase
	endfunction

	// random words with opcodes biased so that every class shows up often
	task automatic fill_image();
		logic [127:0] b;
		logic [2:0]   op;
		int           r;
		for (int i = 0; i < 256; i++) begin
			b = {$random(seed), $random(seed), $random(seed), $random(seed)};
			for (int s = 0; s < NS; s++) begin
				r = $unsigned($random(seed)) % 100;
				if (r < 40)
					op = (r % 4 == 0) ? 3'd0 : 3'(4 + r % 4);
				else if (r < 54)
					op = 3'd1;
				else if (r < 68)
					op = 3'd2;
				else if (r < 84)
					op = 3'd3;
				else
					op = 3'd4;
				b[40*s+37 +: 3] = op;
			end
			image[i] = b;
		end
	endtask

	// ==============================
	// reference model
	// ==============================

	task automatic predict(input logic [AW-1:0] ip, output logic [NS-1:0] mask,
			output logic [AW-1:0] next_ip);
		logic [127:0]  b;
		logic [39:0]   insn;
		logic [AW-5:0] ba;
		logic [AW-1:0] ret_addr;
		logic          done;
		b = image[ip[11:4]];
		ba = ip[AW-1:4];
		mask = '0;
		next_ip = {ba + 1'b1, 4'h0};
		done = 1'b0;
		for (int s = 0; s < NS; s++) begin
			if (s >= start_slot(ip[3:0]) && !done) begin
				insn = b[40*s +: 40];
				mask[s] = 1'b1;
				case (op_class(insn[39:37]))
					ic_br_not: begin
						not_taken_seen++;
					end
					ic_br_taken: begin
						next_ip = {ba + {{(AW-20){insn[36]}}, insn[36:21]},
							target_nibble(insn[1:0])};
						done = 1'b1;
					end
					ic_jc: begin
						next_ip = {insn[36:9], target_nibble(insn[1:0])};
						if (s == 0)
							ret_addr = {ba, 4'h5};
						else if (s == 1)
							ret_addr = {ba, 4'hA};
						else
							ret_addr = {ba + 1'b1, 4'h0};
						ras_model.push_front(ret_addr);
						if (ras_model.size() > `FE_RAS_DEPTH) begin
							void'(ras_model.pop_back());
							overflow_pushes++;
						end
						done = 1'b1;
					end
					ic_ret: begin
						if (ras_model.size() == 0) begin
							next_ip = RST_IP;
							empty_pops++;
						end else begin
							next_ip = ras_model.pop_front();
						end
						done = 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	endtask

	// ==============================
	// port agents
	// ==============================

	task automatic memory_responder();
		forever begin
			step();
			if (mem_req && !mem_ack) begin
				check_value("mem_addr", {model_ip[AW-1:4], 4'h0}, mem_addr);
				last_fetch_addr = mem_addr;
				idle_cycles(rand_delay());
				mem_data = image[mem_addr[11:4]];
				mem_ack = 1'b1;
				while (mem_req)
					step();
				idle_cycles(rand_delay());
				mem_ack = 1'b0;
			end
		end
	endtask

	task automatic issue_acknowledger();
		logic [NS-1:0] exp_mask;
		logic [AW-1:0] exp_next;
		forever begin
			step();
			if (issue_req && !issue_ack) begin
				if (miss_pending) begin
					check_value("issue_data.ip after miss", miss_target, issue_data.ip);
					miss_pending = 1'b0;
				end
				check_value("issue_data.ip", model_ip, issue_data.ip);
				check_value("issue_data.bundle", image[last_fetch_addr[11:4]],
					issue_data.bundle);
				predict(model_ip, exp_mask, exp_next);
				check_value("issue_data.mask", exp_mask, issue_data.mask);
				idle_cycles(rand_delay());
				issue_ack = 1'b1;
				while (issue_req)
					step();
				idle_cycles(rand_delay());
				issue_ack = 1'b0;
				model_ip = exp_next;
				bundles_issued++;
			end
		end
	endtask

	// the first bundle always comes from the reset pointer, misses start after it
	task automatic miss_driver();
		int gap;
		while (bundles_issued == 0)
			step();
		forever begin
			gap = 10 + $unsigned($random(seed)) % 40;
			idle_cycles(gap);
			miss_ip = {RST_IP[AW-1:12], 8'($random(seed)), target_nibble(2'($random(seed)))};
			miss_req = 1'b1;
			step();
			while (!miss_ack)
				step();
			model_ip = miss_ip;
			miss_target = miss_ip;
			miss_pending = 1'b1;
			idle_cycles(rand_delay());
			miss_req = 1'b0;
			while (miss_ack)
				step();
			misses_done++;
		end
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin : main
		rst = 1'b1;
		mem_ack = 1'b0;
		mem_data = '0;
		issue_ack = 1'b0;
		miss_req = 1'b0;
		miss_ip = '0;
		fill_image();
		idle_cycles(RESET_CYCLES);
		check_value("mem_req", 1'b0, mem_req);
		check_value("issue_req", 1'b0, issue_req);
		check_value("miss_ack", 1'b0, miss_ack);
		rst = 1'b0;
		fork
			memory_responder();
			issue_acknowledger();
			miss_driver();
		join_none
		while (bundles_issued < NUM_BUNDLES)
			step();
		check_value("stack overflow seen", 1'b1, overflow_pushes > 0);
		check_value("return from empty stack seen", 1'b1, empty_pops > 0);
		check_value("not-taken branch seen", 1'b1, not_taken_seen > 0);
		check_value("miss served", 1'b1, misses_done > 0);
		$display("%0d bundles issued, %0d misses served", bundles_issued, misses_done);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
